// ==== flist.f ====
+incdir+.
rom_fabric_pkg.sv
bank_req_if.sv
slot_decode.sv
bank_slot.sv
ok_return.sv
rom_fabric.sv
tb_rom_fabric.sv

// ==== tb_rom_fabric.sv ====
`include "rom_fabric_cfg.svh"

module tb_rom_fabric
    import rom_fabric_pkg::*;
();

    logic        clk;
    logic        reset;
    logic [3:0]  cs;
    sdram_addr_t cl_addr [4];
    logic [15:0] main_rom_data;
    logic [7:0]  snd_data;
    logic [7:0]  pcm_data;
    rom_word_t   gfx_data;
    logic        main_rom_ok;
    logic        snd_ok;
    logic        pcm_ok;
    logic        gfx_ok;
    sdram_addr_t ba_addr [4];
    logic [3:0]  ba_rd;
    logic [3:0]  ba_ack = '0;
    logic [3:0]  ba_dst = '0;
    logic [3:0]  ba_dok = '0;
    logic [3:0]  ba_rdy = '0;
    sdram_beat_t data_read = '0;

    // SDRAM model state per bank, one data bus shared by all banks
    int          phase [4] = '{default: 0};
    int          delay [4];
    sdram_addr_t fetch_addr [4];
    int          bus_owner = -1;
    int          delay_pool [64];
    int          pool_idx = 0;
    logic [3:0]  hold_ack;

    string       test_name;
    int          errors;
    int          timeouts;
    rom_word_t   act_data [4];
    logic [3:0]  ok;

    rom_fabric u_rom_fabric (
        .clk           ( clk                ),
        .reset         ( reset              ),
        .main_rom_cs   ( cs[0]              ),
        .snd_cs        ( cs[1]              ),
        .pcm_cs        ( cs[2]              ),
        .gfx_cs        ( cs[3]              ),
        .main_rom_addr ( cl_addr[0][20:0]   ),
        .snd_addr      ( cl_addr[1][15:0]   ),
        .pcm_addr      ( cl_addr[2][17:0]   ),
        .gfx_addr      ( cl_addr[3][19:0]   ),
        .main_rom_data ( main_rom_data      ),
        .snd_data      ( snd_data           ),
        .pcm_data      ( pcm_data           ),
        .gfx_data      ( gfx_data           ),
        .main_rom_ok   ( main_rom_ok        ),
        .snd_ok        ( snd_ok             ),
        .pcm_ok        ( pcm_ok             ),
        .gfx_ok        ( gfx_ok             ),
        .ba0_addr      ( ba_addr[0]         ),
        .ba1_addr      ( ba_addr[1]         ),
        .ba2_addr      ( ba_addr[2]         ),
        .ba3_addr      ( ba_addr[3]         ),
        .ba_rd         ( ba_rd              ),
        .ba_ack        ( ba_ack             ),
        .ba_dst        ( ba_dst             ),
        .ba_dok        ( ba_dok             ),
        .ba_rdy        ( ba_rdy             ),
        .data_read     ( data_read          )
    );

    assign act_data[0] = 32'(main_rom_data);
    assign act_data[1] = 32'(snd_data);
    assign act_data[2] = 32'(pcm_data);
    assign act_data[3] = gfx_data;
    assign ok = {gfx_ok, pcm_ok, snd_ok, main_rom_ok};

    // SDRAM word address of a client address, region offset included
    function automatic sdram_addr_t word_addr(input int c, input sdram_addr_t a);
        case (c)
            0: return (a & ~22'd1) + `BANK0_OFFSET;
            1: return ((a >> 2) << 1) + `BANK1_OFFSET;
            2: return ((a >> 2) << 1) + `BANK2_OFFSET;
            default: return (a << 1) + `BANK3_OFFSET;
        endcase
    endfunction

    function automatic sdram_beat_t beat_value(input int b, input sdram_addr_t a);
        return a[15:0] ^ (16'h1111 * b[15:0]);
    endfunction

    function automatic rom_word_t exp_data(input int c, input sdram_addr_t a);
        sdram_addr_t w;
        rom_word_t   word;
        w = word_addr(c, a);
        word = {beat_value(c, w + 22'd1), beat_value(c, w)};
        case (c)
            0: return a[0] ? word[31:16] : word[15:0];
            1, 2: return (word >> (8 * a[1:0])) & 32'hff;
            default: return word;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ack after a drawn delay, then two beats once the data bus is free
    always @(negedge clk) begin
        ba_ack = '0;
        ba_dst = '0;
        ba_dok = '0;
        ba_rdy = '0;
        data_read = '0;
        for (int b = 0; b < 4; b++) begin
            if (phase[b] == 0 && ba_rd[b]) begin
                delay[b] = delay_pool[pool_idx % 64];
                pool_idx++;
                fetch_addr[b] = ba_addr[b];
                phase[b] = 1;
            end
            if (phase[b] == 1) begin
                if (delay[b] == 0 && !hold_ack[b]) begin
                    ba_ack[b] = 1'b1;
                    phase[b] = 2;
                end else if (delay[b] != 0) begin
                    delay[b]--;
                end
            end else if (phase[b] == 2 && bus_owner < 0) begin
                bus_owner = b;
                data_read = beat_value(b, fetch_addr[b]);
                ba_dok[b] = 1'b1;
                ba_dst[b] = 1'b1;
                phase[b] = 3;
            end else if (phase[b] == 3) begin
                data_read = beat_value(b, fetch_addr[b] + 22'd1);
                ba_dok[b] = 1'b1;
                ba_rdy[b] = 1'b1;
                phase[b] = 4;
            end else if (phase[b] == 4) begin
                bus_owner = -1;
                phase[b] = 0;
            end
        end
    end

    for (genvar b = 0; b < `ROM_FABRIC_BANKS; b++) begin : g_check
        a_data: assert property (
            @(posedge clk) disable iff (reset)
            ok[b] |-> act_data[b] == exp_data(b, cl_addr[b])
        ) else begin
            errors++;
            $display("Error %s client %0d: expected %h actual %h", test_name, b,
                     exp_data(b, $sampled(cl_addr[b])), $sampled(act_data[b]));
        end

        a_hold: assert property (
            @(posedge clk) disable iff (reset)
            ba_rd[b] && !ba_ack[b] |=> ba_rd[b] && $stable(ba_addr[b])
        ) else begin
            errors++;
            $display("Bank %0d dropped ba_rd or moved its address before ba_ack in %s",
                     b, test_name);
        end

        a_ok_cs: assert property (
            @(posedge clk) disable iff (reset)
            !cs[b] |-> !ok[b]
        ) else begin
            errors++;
            $display("Client %0d raised ok without cs in %s", b, test_name);
        end
    end

    task automatic wait_ok(input logic [3:0] mask, output bit seen);
        seen = 1'b0;
        for (int n = 0; n < 300; n++) begin
            @(negedge clk);
            if ((ok & mask) == mask) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout in %s: ok never came for mask %b", test_name, mask);
        end
    endtask

    task automatic check_bank_addr(input int c);
        assert (ba_addr[c] == word_addr(c, cl_addr[c])) else begin
            errors++;
            $display("Error %s bank %0d address: expected %h actual %h", test_name, c,
                     word_addr(c, cl_addr[c]), ba_addr[c]);
        end
    endtask

    // One read with cs held one cycle past ok, so the data check samples it
    task automatic read_client(input int c, input sdram_addr_t a);
        bit seen;
        @(negedge clk);
        cs[c] = 1'b1;
        cl_addr[c] = a;
        wait_ok(4'b0001 << c, seen);
        if (seen) begin
            check_bank_addr(c);
        end
        @(negedge clk);
        cs[c] = 1'b0;
    endtask

    initial begin
        int          seed_val;
        bit          seen;
        sdram_addr_t base;
        seed_val = $urandom(32'h9df6_e1c9);
        foreach (delay_pool[i]) begin
            delay_pool[i] = $urandom_range(6, 0);
        end
        cs = '0;
        cl_addr = '{default: '0};
        hold_ack = '0;
        errors = 0;
        timeouts = 0;
        test_name = "reset";
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        repeat (3) begin
            @(negedge clk);
            assert (ba_rd == 4'b0 && ok == 4'b0) else begin
                errors++;
                $display("Error %s: expected %h actual %h", test_name, 8'h00, {ba_rd, ok});
            end
        end

        test_name = "main_half";
        base = $urandom & 22'h0f_fffe;
        read_client(0, base);
        read_client(0, base | 22'd1);

        test_name = "byte_lanes";
        for (int c = 1; c <= 2; c++) begin
            base = $urandom & 22'h00_fffc;
            for (int k = 0; k < 4; k++) begin
                read_client(c, base | k);
            end
        end

        test_name = "gfx_word";
        read_client(3, $urandom & 22'h0f_ffff);
        read_client(3, $urandom & 22'h0f_ffff);

        test_name = "all_clients";
        repeat (8) begin
            @(negedge clk);
            cs = 4'hf;
            cl_addr[0] = $urandom & 22'h0f_ffff;
            cl_addr[1] = $urandom & 22'h00_ffff;
            cl_addr[2] = $urandom & 22'h03_ffff;
            cl_addr[3] = $urandom & 22'h0f_ffff;
            wait_ok(4'hf, seen);
            @(negedge clk);
            cs = 4'h0;
        end

        // Two address moves while the first fetch is held at the SDRAM
        test_name = "addr_change";
        hold_ack = 4'b0001;
        @(negedge clk);
        cs[0] = 1'b1;
        cl_addr[0] = 22'h10_0000;
        repeat (3) @(negedge clk);
        cl_addr[0] = 22'h10_0400;
        repeat (2) @(negedge clk);
        cl_addr[0] = 22'h10_0803;
        repeat (2) @(negedge clk);
        assert (!main_rom_ok) else begin
            errors++;
            $display("Main ROM ok rose while its fetch was still held in %s", test_name);
        end
        hold_ack = 4'b0000;
        wait_ok(4'b0001, seen);
        if (seen) begin
            check_bank_addr(0);
        end
        @(negedge clk);
        cs[0] = 1'b0;

        repeat (4) @(negedge clk);
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (40000) @(posedge clk);
        $display("Run stopped by the watchdog before the tests completed");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== rom_fabric.sv ====
`include "rom_fabric_cfg.svh"

module rom_fabric
    import rom_fabric_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    // ROM clients
    input  logic                         main_rom_cs,
    input  logic                         snd_cs,
    input  logic                         pcm_cs,
    input  logic                         gfx_cs,
    input  logic [20:0]                  main_rom_addr,
    input  logic [15:0]                  snd_addr,
    input  logic [17:0]                  pcm_addr,
    input  logic [19:0]                  gfx_addr,
    output logic [15:0]                  main_rom_data,
    output logic [7:0]                   snd_data,
    output logic [7:0]                   pcm_data,
    output rom_word_t                    gfx_data,
    output logic                         main_rom_ok,
    output logic                         snd_ok,
    output logic                         pcm_ok,
    output logic                         gfx_ok,
    // SDRAM controller
    output sdram_addr_t                  ba0_addr,
    output sdram_addr_t                  ba1_addr,
    output sdram_addr_t                  ba2_addr,
    output sdram_addr_t                  ba3_addr,
    output logic [`ROM_FABRIC_BANKS-1:0] ba_rd,
    input  logic [`ROM_FABRIC_BANKS-1:0] ba_ack,
    input  logic [`ROM_FABRIC_BANKS-1:0] ba_dst,
    input  logic [`ROM_FABRIC_BANKS-1:0] ba_dok,
    input  logic [`ROM_FABRIC_BANKS-1:0] ba_rdy,
    input  sdram_beat_t                  data_read
);

    sdram_addr_t ba_addr [`ROM_FABRIC_BANKS];

    bank_req_if u_bank_if [`ROM_FABRIC_BANKS] ();

    slot_decode u_slot_decode (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .main_rom_cs   ( main_rom_cs   ),
        .snd_cs        ( snd_cs        ),
        .pcm_cs        ( pcm_cs        ),
        .gfx_cs        ( gfx_cs        ),
        .main_rom_addr ( main_rom_addr ),
        .snd_addr      ( snd_addr      ),
        .pcm_addr      ( pcm_addr      ),
        .gfx_addr      ( gfx_addr      ),
        .bank          ( u_bank_if     )
    );

    // Banks run independently, one fetch in flight each
    for (genvar i = 0; i < `ROM_FABRIC_BANKS; i++) begin : g_bank
        bank_slot #(
            .BANK ( i )
        ) u_bank_slot (
            .clk       ( clk          ),
            .reset     ( reset        ),
            .req_port  ( u_bank_if[i] ),
            .ba_addr   ( ba_addr[i]   ),
            .ba_rd     ( ba_rd[i]     ),
            .ba_ack    ( ba_ack[i]    ),
            .ba_dst    ( ba_dst[i]    ),
            .ba_dok    ( ba_dok[i]    ),
            .ba_rdy    ( ba_rdy[i]    ),
            .data_read ( data_read    )
        );
    end

    assign ba0_addr = ba_addr[0];
    assign ba1_addr = ba_addr[1];
    assign ba2_addr = ba_addr[2];
    assign ba3_addr = ba_addr[3];

    ok_return u_ok_return (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .main_rom_cs   ( main_rom_cs   ),
        .snd_cs        ( snd_cs        ),
        .pcm_cs        ( pcm_cs        ),
        .gfx_cs        ( gfx_cs        ),
        .main_rom_addr ( main_rom_addr ),
        .snd_addr      ( snd_addr      ),
        .pcm_addr      ( pcm_addr      ),
        .gfx_addr      ( gfx_addr      ),
        .bank          ( u_bank_if     ),
        .main_rom_data ( main_rom_data ),
        .snd_data      ( snd_data      ),
        .pcm_data      ( pcm_data      ),
        .gfx_data      ( gfx_data      ),
        .main_rom_ok   ( main_rom_ok   ),
        .snd_ok        ( snd_ok        ),
        .pcm_ok        ( pcm_ok        ),
        .gfx_ok        ( gfx_ok        )
    );

endmodule

// ==== ok_return.sv ====
`include "rom_fabric_cfg.svh"

module ok_return
    import rom_fabric_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        main_rom_cs,
    input  logic        snd_cs,
    input  logic        pcm_cs,
    input  logic        gfx_cs,
    input  logic [20:0] main_rom_addr,
    input  logic [15:0] snd_addr,
    input  logic [17:0] pcm_addr,
    input  logic [19:0] gfx_addr,
    bank_req_if.ret     bank [`ROM_FABRIC_BANKS],
    output logic [15:0] main_rom_data,
    output logic [7:0]  snd_data,
    output logic [7:0]  pcm_data,
    output rom_word_t   gfx_data,
    output logic        main_rom_ok,
    output logic        snd_ok,
    output logic        pcm_ok,
    output logic        gfx_ok
);

    localparam int N = `ROM_FABRIC_BANKS;

    logic        cs      [N];
    sdram_addr_t aligned [N];
    rom_word_t   word    [N];
    sdram_addr_t tag     [N];
    logic        valid   [N];
    logic        ok      [N];

    assign cs[0] = main_rom_cs;
    assign cs[1] = snd_cs;
    assign cs[2] = pcm_cs;
    assign cs[3] = gfx_cs;

    assign aligned[0] = align_half(sdram_addr_t'(main_rom_addr));
    assign aligned[1] = align_byte(sdram_addr_t'(snd_addr));
    assign aligned[2] = align_byte(sdram_addr_t'(pcm_addr));
    assign aligned[3] = align_word(sdram_addr_t'(gfx_addr));

    for (genvar i = 0; i < N; i++) begin : g_client

        always_ff @(posedge clk) begin
            if (reset) begin
                valid[i] <= 1'b0;
            end else if (bank[i].rsp_valid) begin
                valid[i] <= 1'b1;
            end
        end

        // Only the latest word is kept per client
        always_ff @(posedge clk) begin
            if (bank[i].rsp_valid) begin
                word[i] <= bank[i].rsp_data;
                tag[i]  <= bank[i].rsp_addr;
            end
        end

        assign ok[i] = cs[i] && valid[i] && (tag[i] == aligned[i]);

        a_ok_cs: assert property (
            @(posedge clk) disable iff (reset)
            !cs[i] |-> !ok[i]
        ) else $error("client %0d: ok high with cs low", i);

    end

    // Half and byte lanes picked by the low address bits
    assign main_rom_data = main_rom_addr[0] ? word[0][31:16] : word[0][15:0];
    assign snd_data      = word[1][8*snd_addr[1:0] +: 8];
    assign pcm_data      = word[2][8*pcm_addr[1:0] +: 8];
    assign gfx_data      = word[3];

    assign main_rom_ok = ok[0];
    assign snd_ok      = ok[1];
    assign pcm_ok      = ok[2];
    assign gfx_ok      = ok[3];

endmodule

// ==== bank_slot.sv ====
module bank_slot
    import rom_fabric_pkg::*;
#(
    parameter int BANK = 0
) (
    input  logic        clk,
    input  logic        reset,
    bank_req_if.slot    req_port,
    output sdram_addr_t ba_addr,
    output logic        ba_rd,
    input  logic        ba_ack,
    input  logic        ba_dst,
    input  logic        ba_dok,
    input  logic        ba_rdy,
    input  sdram_beat_t data_read
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DONE
    } state_t;

    state_t      state;
    logic        pend_vld;
    sdram_addr_t pend_addr;
    sdram_addr_t pend_tag;
    sdram_addr_t tag;
    sdram_beat_t low_beat;

    logic        busy;
    logic        finish;
    logic        launch;
    logic        next_vld;
    sdram_addr_t next_addr;
    sdram_addr_t next_tag;

    assign busy   = (state == REQ) || (state == WAIT);
    assign finish = (state == WAIT) && ba_rdy;

    // A request in the same cycle is newer than the pending one
    assign next_vld  = req_port.req || pend_vld;
    assign next_addr = req_port.req ? req_port.req_addr : pend_addr;
    assign next_tag  = req_port.req ? req_port.req_tag  : pend_tag;

    assign launch = (!busy && req_port.req) || (finish && next_vld);

    assign ba_rd = (state == REQ);

    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= IDLE;
            pend_vld           <= 1'b0;
            req_port.rsp_valid <= 1'b0;
        end else begin
            req_port.rsp_valid <= finish;
            case (state)
                IDLE, DONE: begin
                    state <= req_port.req ? REQ : IDLE;
                end
                REQ: begin
                    if (ba_ack) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (finish) begin
                        state <= next_vld ? REQ : DONE;
                    end
                end
                default: state <= IDLE;
            endcase
            // Only the newest address waits behind the running fetch
            if (finish) begin
                pend_vld <= 1'b0;
            end else if (busy && req_port.req) begin
                pend_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            ba_addr <= next_addr;
            tag     <= next_tag;
        end
        if (busy && req_port.req && !finish) begin
            pend_addr <= req_port.req_addr;
            pend_tag  <= req_port.req_tag;
        end
        if (busy && ba_dok && ba_dst) begin
            low_beat <= data_read;
        end
        if (finish) begin
            req_port.rsp_addr <= tag;
            req_port.rsp_data <= {data_read, low_beat};
        end
    end

    // SDRAM controller needs a steady request until it takes it
    a_rd_hold: assert property (
        @(posedge clk) disable iff (reset)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr)
    ) else $error("bank %0d: ba_rd or ba_addr moved before ba_ack", BANK);

    a_dok_idle: assert property (
        @(posedge clk) disable iff (reset)
        ba_dok |-> state == WAIT
    ) else $error("bank %0d: ba_dok with no fetch running", BANK);

endmodule

// ==== slot_decode.sv ====
`include "rom_fabric_cfg.svh"

module slot_decode
    import rom_fabric_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        main_rom_cs,
    input  logic        snd_cs,
    input  logic        pcm_cs,
    input  logic        gfx_cs,
    input  logic [20:0] main_rom_addr,
    input  logic [15:0] snd_addr,
    input  logic [17:0] pcm_addr,
    input  logic [19:0] gfx_addr,
    bank_req_if.decode  bank [`ROM_FABRIC_BANKS]
);

    localparam int N = `ROM_FABRIC_BANKS;

    logic        cs        [N];
    sdram_addr_t aligned   [N];
    sdram_addr_t offset    [N];
    logic        cs_q      [N];
    sdram_addr_t aligned_q [N];

    assign cs[0] = main_rom_cs;
    assign cs[1] = snd_cs;
    assign cs[2] = pcm_cs;
    assign cs[3] = gfx_cs;

    // Each client counts in its own unit
    assign aligned[0] = align_half(sdram_addr_t'(main_rom_addr));
    assign aligned[1] = align_byte(sdram_addr_t'(snd_addr));
    assign aligned[2] = align_byte(sdram_addr_t'(pcm_addr));
    assign aligned[3] = align_word(sdram_addr_t'(gfx_addr));

    assign offset[0] = `BANK0_OFFSET;
    assign offset[1] = `BANK1_OFFSET;
    assign offset[2] = `BANK2_OFFSET;
    assign offset[3] = `BANK3_OFFSET;

    for (genvar i = 0; i < N; i++) begin : g_client

        always_ff @(posedge clk) begin
            if (reset) begin
                cs_q[i]     <= 1'b0;
                bank[i].req <= 1'b0;
            end else begin
                cs_q[i] <= cs[i];
                // New fetch on a cs rise or when a different word is wanted
                bank[i].req <= cs[i] && (!cs_q[i] || aligned[i] != aligned_q[i]);
            end
        end

        always_ff @(posedge clk) begin
            aligned_q[i]     <= aligned[i];
            bank[i].req_addr <= aligned[i] + offset[i];
            bank[i].req_tag  <= aligned[i];
        end

        // A request only goes out while its client is still selected
        a_req_cs: assert property (
            @(posedge clk) disable iff (reset)
            bank[i].req |-> cs[i]
        ) else $error("client %0d: req while cs is low", i);

    end

endmodule

// ==== bank_req_if.sv ====
interface bank_req_if
    import rom_fabric_pkg::*;
();

    // Request side, single-cycle pulse with its address
    logic        req;
    sdram_addr_t req_addr;
    // Same address without the region offset
    sdram_addr_t req_tag;

    // Response side, single-cycle pulse
    logic        rsp_valid;
    sdram_addr_t rsp_addr;
    rom_word_t   rsp_data;

    modport decode (
        output req,
        output req_addr,
        output req_tag
    );

    modport slot (
        input  req,
        input  req_addr,
        input  req_tag,
        output rsp_valid,
        output rsp_addr,
        output rsp_data
    );

    modport ret (
        input  rsp_valid,
        input  rsp_addr,
        input  rsp_data
    );

endinterface

// ==== rom_fabric_pkg.sv ====
`include "rom_fabric_cfg.svh"

package rom_fabric_pkg;

    typedef logic [`SDRAM_AW-1:0]   sdram_addr_t;
    typedef logic [`ROM_BEAT_W-1:0] sdram_beat_t;

    // First beat sits in the low half
    typedef logic [`ROM_WORD_W-1:0] rom_word_t;

    // Half address, bit 0 picks the half inside the word
    function automatic sdram_addr_t align_half(input sdram_addr_t a);
        return {a[`SDRAM_AW-1:1], 1'b0};
    endfunction

    // Byte address, two low bits pick the byte lane
    function automatic sdram_addr_t align_byte(input sdram_addr_t a);
        return {1'b0, a[`SDRAM_AW-1:2], 1'b0};
    endfunction

    // Word address, each word spans two SDRAM locations
    function automatic sdram_addr_t align_word(input sdram_addr_t a);
        return {a[`SDRAM_AW-2:0], 1'b0};
    endfunction

endpackage

// ==== rom_fabric_cfg.svh ====
`ifndef ROM_FABRIC_CFG_SVH
`define ROM_FABRIC_CFG_SVH

// One SDRAM bank per ROM client
`define ROM_FABRIC_BANKS 4

// SDRAM word address and data widths
`define SDRAM_AW   22
`define ROM_BEAT_W 16
`define ROM_WORD_W 32

// Region start of each client, in 16-bit words
`define BANK0_OFFSET 22'h00_0000
`define BANK1_OFFSET 22'h08_0000
`define BANK2_OFFSET 22'h10_0000
`define BANK3_OFFSET 22'h20_0000

`endif
